// ==== exe_pipe_top.f ====
+incdir+tb
source/exe_pkg.sv
source/adder64.sv
source/operand_select.sv
source/alu.sv
source/branch_unit.sv
source/exe_stage.sv
source/exe_pipe_top.sv
tb/exe_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns -f exe_pipe_top.f \
	--top-module exe_pipe_tb -o exe_pipe_sim
./obj_dir/exe_pipe_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "test passed" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

// ==== source/adder64.sv ====
`timescale 1ns/1ns

module adder64 import exe_pkg::*; (
	input  reg_t       op1,
	input  reg_t       op2,
	input  logic       cin,
	output reg_t       sum,
	output add_flags_t flags
);

	logic [xlen:0] full_sum; // One extra bit keeps the carry out.

	assign full_sum = {1'b0, op1} + {1'b0, op2} + {{xlen{1'b0}}, cin};
	assign sum = full_sum[xlen-1:0];

	assign flags.zero = (sum == '0);
	assign flags.sign = sum[xlen-1];

	// Operands of equal sign giving a result of the other sign.
	assign flags.overflow = (op1[xlen-1] == op2[xlen-1]) && (sum[xlen-1] != op1[xlen-1]);

	// With op2 inverted and cin set, no carry out means op1 < op2 unsigned.
	assign flags.borrow = ~full_sum[xlen];

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu import exe_pkg::*; (
	input  alu_op_e    alu_op,
	input  reg_t       op1,
	input  reg_t       op2,
	output reg_t       alu_result,
	output add_flags_t flags
);

	logic  sub_mode;
	reg_t  add_op2;
	reg_t  add_sum;
	reg_t  sll_res;
	reg_t  srl_res;
	reg_t  sra_res;
	word_t sllw_res;
	word_t srlw_res;
	word_t sraw_res;

	function automatic reg_t sext_word(word_t w);
		return {{(xlen-wlen){w[wlen-1]}}, w};
	endfunction

	// Subtracts, compares and branches all use op1 - op2.
	always_comb begin
		case (alu_op)
			alu_sub, alu_subw, alu_slt, alu_sltu,
			alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu:
				sub_mode = 1'b1;
			default:
				sub_mode = 1'b0;
		endcase
	end

	assign add_op2 = sub_mode ? ~op2 : op2; // Two's complement with cin.

	adder64 u_adder (
		.op1   (op1),
		.op2   (add_op2),
		.cin   (sub_mode),
		.sum   (add_sum),
		.flags (flags)
	);

	// 64-bit shifts use six bits of op2, word shifts use five.
	assign sll_res  = op1 << op2[5:0];
	assign srl_res  = op1 >> op2[5:0];
	assign sra_res  = $signed(op1) >>> op2[5:0];
	assign sllw_res = op1[wlen-1:0] << op2[4:0];
	assign srlw_res = op1[wlen-1:0] >> op2[4:0];
	assign sraw_res = $signed(op1[wlen-1:0]) >>> op2[4:0];

	always_comb begin
		case (alu_op)
			alu_add:  alu_result = add_sum;
			alu_sub:  alu_result = add_sum;
			alu_addw: alu_result = sext_word(add_sum[wlen-1:0]);
			alu_subw: alu_result = sext_word(add_sum[wlen-1:0]);
			alu_slt:  alu_result = {{(xlen-1){1'b0}}, flags.sign ^ flags.overflow};
			alu_sltu: alu_result = {{(xlen-1){1'b0}}, flags.borrow};
			alu_xor:  alu_result = op1 ^ op2;
			alu_or:   alu_result = op1 | op2;
			alu_and:  alu_result = op1 & op2;
			alu_sll:  alu_result = sll_res;
			alu_srl:  alu_result = srl_res;
			alu_sra:  alu_result = sra_res;
			alu_sllw: alu_result = sext_word(sllw_res);
			alu_srlw: alu_result = sext_word(srlw_res);
			alu_sraw: alu_result = sext_word(sraw_res);
			alu_lui:  alu_result = op2; // Immediate already shifted by decode.
			default:  alu_result = '0;  // Branches and none.
		endcase
	end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit import exe_pkg::*; (
	input  alu_op_e    alu_op,
	input  add_flags_t flags,
	input  reg_t       pc,
	input  reg_t       rs1_val,
	input  reg_t       imm,
	input  logic       pc_from_rs1,
	output logic       taken,
	output reg_t       target_pc
);

	reg_t base;
	reg_t target_sum;

	// Flags come from op1 - op2 in the ALU adder.
	always_comb begin
		case (alu_op)
			alu_beq:  taken = flags.zero;
			alu_bne:  taken = ~flags.zero;
			alu_blt:  taken = flags.sign ^ flags.overflow;
			alu_bge:  taken = ~(flags.sign ^ flags.overflow);
			alu_bltu: taken = flags.borrow;
			alu_bgeu: taken = ~flags.borrow;
			default:  taken = 1'b0;
		endcase
	end

	assign base = pc_from_rs1 ? rs1_val : pc; // JALR jumps relative to rs1.

	adder64 u_target_adder (
		.op1   (base),
		.op2   (imm),
		.cin   (1'b0),
		.sum   (target_sum),
		.flags ()
	);

	// JALR clears the low bit of the target.
	assign target_pc = {target_sum[xlen-1:1], target_sum[0] & ~pc_from_rs1};

endmodule

// ==== source/exe_pipe_top.sv ====
`timescale 1ns/1ns

module exe_pipe_top import exe_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  issue_t     issue,
	output ex_result_t ex_out,
	output wb_result_t wb_out
);

	ex_result_t ex_next;
	wb_result_t wb_next;

	// Both pipeline registers act as forwarding sources.
	exe_stage u_exe_stage (
		.issue     (issue),
		.me_result (ex_out.alu_result),
		.wb_result (wb_out.rd_data),
		.result    (ex_next)
	);

	// No data memory, so the memory stage hands the ALU result on.
	assign wb_next.valid   = ex_out.valid;
	assign wb_next.rd_data = ex_out.alu_result;

	always_ff @(posedge clk) begin
		ex_out <= ex_next;
		wb_out <= wb_next;
		if (rst) begin
			ex_out.valid <= 1'b0;
			wb_out.valid <= 1'b0;
		end
	end

	// Nothing valid leaves either register right after a reset cycle.
	assert property (@(posedge clk) $past(rst) |-> !ex_out.valid && !wb_out.valid)
	else
		$error("exe_pipe_top: valid high after reset ex=%h wb=%h",
			ex_out.valid, wb_out.valid);

	// A taken branch in EX/MEM always comes from a real issued entry.
	assert property (@(posedge clk) disable iff (rst) ex_out.taken |-> ex_out.valid)
	else
		$error("exe_pipe_top: taken=%h on a bubble", ex_out.taken);

endmodule

// ==== source/exe_pkg.sv ====
package exe_pkg;

	localparam int xlen = 64; // Register width.
	localparam int wlen = 32; // Width of the word-form operations.

	typedef logic [xlen-1:0] reg_t;
	typedef logic [wlen-1:0] word_t;

	// Added to pc to form the jal/jalr link value.
	localparam reg_t link_offset = 64'd4;

	typedef enum logic [4:0] {
		alu_add,
		alu_addw,
		alu_sub,
		alu_subw,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_sllw,
		alu_srlw,
		alu_sraw,
		alu_lui,
		alu_beq,
		alu_bne,
		alu_blt,
		alu_bge,
		alu_bltu,
		alu_bgeu,
		alu_none
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_reg, // Value read from the register file.
		fwd_mem, // Result held in EX/MEM.
		fwd_wb   // Result held in MEM/WB.
	} fwd_sel_e;

	typedef enum logic {
		op1_rs1,
		op1_pc
	} op1_sel_e;

	typedef enum logic [1:0] {
		op2_rs2,
		op2_imm,
		op2_const4
	} op2_sel_e;

	typedef struct packed {
		logic     zero;
		logic     sign;
		logic     overflow;
		logic     borrow; // Meaningful only when the adder subtracts.
	} add_flags_t;

	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		reg_t     pc;
		reg_t     imm;
		reg_t     rs1_data;
		reg_t     rs2_data;
		fwd_sel_e rs1_fwd;
		fwd_sel_e rs2_fwd;
		op1_sel_e op1_sel;
		op2_sel_e op2_sel;
		logic     pc_from_rs1; // Set for JALR.
	} issue_t;

	typedef struct packed {
		logic valid;
		reg_t alu_result;
		reg_t store_data; // Forwarded rs2.
		reg_t target_pc;
		logic taken;
	} ex_result_t;

	typedef struct packed {
		logic valid;
		reg_t rd_data;
	} wb_result_t;

endpackage

// ==== source/exe_stage.sv ====
`timescale 1ns/1ns

module exe_stage import exe_pkg::*; (
	input  issue_t     issue,
	input  reg_t       me_result,
	input  reg_t       wb_result,
	output ex_result_t result
);

	reg_t       rs1_val;
	reg_t       rs2_val;
	reg_t       op1;
	reg_t       op2;
	reg_t       alu_result;
	add_flags_t add_flags;
	logic       taken;
	reg_t       target_pc;

	operand_select u_operand_select (
		.rs1_data  (issue.rs1_data),
		.rs2_data  (issue.rs2_data),
		.me_result (me_result),
		.wb_result (wb_result),
		.pc        (issue.pc),
		.imm       (issue.imm),
		.rs1_fwd   (issue.rs1_fwd),
		.rs2_fwd   (issue.rs2_fwd),
		.op1_sel   (issue.op1_sel),
		.op2_sel   (issue.op2_sel),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.op1       (op1),
		.op2       (op2)
	);

	alu u_alu (
		.alu_op     (issue.alu_op),
		.op1        (op1),
		.op2        (op2),
		.alu_result (alu_result),
		.flags      (add_flags)
	);

	branch_unit u_branch_unit (
		.alu_op      (issue.alu_op),
		.flags       (add_flags),
		.pc          (issue.pc),
		.rs1_val     (rs1_val),
		.imm         (issue.imm),
		.pc_from_rs1 (issue.pc_from_rs1),
		.taken       (taken),
		.target_pc   (target_pc)
	);

	assign result.valid      = issue.valid;
	assign result.alu_result = alu_result;
	assign result.store_data = rs2_val;            // Store data sees forwarding too.
	assign result.target_pc  = target_pc;
	assign result.taken      = taken & issue.valid; // A bubble never redirects.

endmodule

// ==== source/operand_select.sv ====
`timescale 1ns/1ns

module operand_select import exe_pkg::*; (
	input  reg_t     rs1_data,
	input  reg_t     rs2_data,
	input  reg_t     me_result,
	input  reg_t     wb_result,
	input  reg_t     pc,
	input  reg_t     imm,
	input  fwd_sel_e rs1_fwd,
	input  fwd_sel_e rs2_fwd,
	input  op1_sel_e op1_sel,
	input  op2_sel_e op2_sel,
	output reg_t     rs1_val,
	output reg_t     rs2_val,
	output reg_t     op1,
	output reg_t     op2
);

	// Picks a register operand from the file or a later stage.
	function automatic reg_t fwd_pick(fwd_sel_e sel, reg_t rf_val, reg_t me_val, reg_t wb_val);
		reg_t val;
		case (sel)
			fwd_mem: val = me_val;
			fwd_wb:  val = wb_val;
			default: val = rf_val;
		endcase
		return val;
	endfunction

	assign rs1_val = fwd_pick(rs1_fwd, rs1_data, me_result, wb_result);
	assign rs2_val = fwd_pick(rs2_fwd, rs2_data, me_result, wb_result);

	assign op1 = (op1_sel == op1_pc) ? pc : rs1_val;

	always_comb begin
		case (op2_sel)
			op2_imm:    op2 = imm;
			op2_const4: op2 = link_offset; // Link value for jal and jalr.
			default:    op2 = rs2_val;
		endcase
	end

	// Decode must never send the unused 2'b11 code.
	always_comb begin
		if (!$isunknown({rs1_fwd, rs2_fwd, op2_sel})) begin
			assert (rs1_fwd inside {fwd_reg, fwd_mem, fwd_wb} &&
				rs2_fwd inside {fwd_reg, fwd_mem, fwd_wb} &&
				op2_sel inside {op2_rs2, op2_imm, op2_const4})
			else
				$error("operand_select: illegal select rs1_fwd=%h rs2_fwd=%h op2_sel=%h",
					rs1_fwd, rs2_fwd, op2_sel);
		end
	end

endmodule

// ==== tb/exe_ref_model.svh ====
`ifndef exe_ref_model_svh
`define exe_ref_model_svh

function automatic reg_t sign_extend_word(word_t w);
	return reg_t'($signed(w));
endfunction

// Expected ALU result from the effective operands.
function automatic reg_t ref_alu(alu_op_e op, reg_t a, reg_t b);
	word_t aw;
	aw = a[31:0];
	case (op)
		alu_add:  return a + b;
		alu_sub:  return a - b;
		alu_addw: return sign_extend_word(aw + b[31:0]);
		alu_subw: return sign_extend_word(aw - b[31:0]);
		alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
		alu_sltu: return (a < b) ? 64'd1 : 64'd0;
		alu_xor:  return a ^ b;
		alu_or:   return a | b;
		alu_and:  return a & b;
		alu_sll:  return a << b[5:0];
		alu_srl:  return a >> b[5:0];
		alu_sra:  return reg_t'($signed(a) >>> b[5:0]);
		alu_sllw: return sign_extend_word(aw << b[4:0]);
		alu_srlw: return sign_extend_word(aw >> b[4:0]);
		alu_sraw: return sign_extend_word(word_t'($signed(aw) >>> b[4:0]));
		alu_lui:  return b;
		default:  return '0; // Branches give no result.
	endcase
endfunction

function automatic logic ref_taken(alu_op_e op, reg_t a, reg_t b);
	case (op)
		alu_beq:  return a == b;
		alu_bne:  return a != b;
		alu_blt:  return $signed(a) < $signed(b);
		alu_bge:  return $signed(a) >= $signed(b);
		alu_bltu: return a < b;
		alu_bgeu: return a >= b;
		default:  return 1'b0;
	endcase
endfunction

function automatic reg_t ref_target(reg_t pc, reg_t rs1, reg_t imm, logic jalr);
	reg_t t;
	t = (jalr ? rs1 : pc) + imm;
	if (jalr)
		t[0] = 1'b0; // JALR drops the low bit.
	return t;
endfunction

`endif

// ==== tb/exe_pipe_tb.sv ====
`timescale 1ns/1ns

module exe_pipe_tb import exe_pkg::*;;

	`include "exe_ref_model.svh"

	localparam logic [1:0] m_rr = 2'd0;   // rs1 and rs2.
	localparam logic [1:0] m_ri = 2'd1;   // rs1 and the immediate.
	localparam logic [1:0] m_jal = 2'd2;  // Link value, target from pc.
	localparam logic [1:0] m_jalr = 2'd3; // Link value, target from rs1.
	localparam reg_t max_pos = {1'b0, {(xlen-1){1'b1}}};
	localparam reg_t min_neg = {1'b1, {(xlen-1){1'b0}}};
	localparam reg_t all_ones = '1;
	localparam reg_t pc_base = 64'h8000_0000;
	localparam reg_t branch_off = 64'h100; // Immediate of the rs1/rs2 entries.

	typedef struct packed {
		alu_op_e    op;
		logic [1:0] mode;
		fwd_sel_e   f1;
		fwd_sel_e   f2;
		reg_t       a;
		reg_t       b;
		logic [1:0] rnd; // Bit 0 makes a random, bit 1 makes b random.
		logic       taken;
	} entry_t;

	logic       clk = 1'b0;
	logic       rst;
	issue_t     issue;
	ex_result_t ex_out;
	wb_result_t wb_out;

	entry_t      table_q[$];
	ex_result_t  exp_q[$];  // Expected results, one per issued entry.
	bit          bad_q[$];  // Test 0 is reset, test i+1 is entry i.
	logic [31:0] lcg_state = 32'h2656e601;
	bit          table_built = 1'b0;
	int          pass_count = 0;
	int          fail_count = 0;

	exe_pipe_top uut (.clk(clk), .rst(rst), .issue(issue), .ex_out(ex_out), .wb_out(wb_out));

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic reg_t random_dword();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi, lo};
	endfunction

	function automatic void add_entry(alu_op_e op, logic [1:0] mode, fwd_sel_e f1, fwd_sel_e f2,
		reg_t a, reg_t b, logic [1:0] rnd, logic taken);
		entry_t e;
		e = '{op, mode, f1, f2, a, b, rnd, taken};
		table_q.push_back(e);
	endfunction

	function automatic void build_table();
		// Add and sub on random operands and at the overflow edges.
		add_entry(alu_add, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_add, m_rr, fwd_reg, fwd_reg, max_pos, 64'd1, 2'b00, 1'b0);
		add_entry(alu_sub, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_sub, m_rr, fwd_reg, fwd_reg, min_neg, 64'd1, 2'b00, 1'b0);
		add_entry(alu_addw, m_rr, fwd_reg, fwd_reg, 64'h7fff_ffff, 64'd1, 2'b00, 1'b0);
		add_entry(alu_subw, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd1, 2'b00, 1'b0);
		add_entry(alu_slt, m_rr, fwd_reg, fwd_reg, all_ones, 64'd1, 2'b00, 1'b0);
		add_entry(alu_slt, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b0);
		add_entry(alu_sltu, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b0);
		add_entry(alu_sltu, m_rr, fwd_reg, fwd_reg, all_ones, 64'd1, 2'b00, 1'b0);
		add_entry(alu_xor, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_or, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_and, m_ri, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		// Shift amounts 0, 31, 32 and 63.
		add_entry(alu_sll, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b01, 1'b0);
		add_entry(alu_sll, m_ri, fwd_reg, fwd_reg, 64'd0, 64'd63, 2'b01, 1'b0);
		add_entry(alu_srl, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd32, 2'b01, 1'b0);
		add_entry(alu_sra, m_rr, fwd_reg, fwd_reg, min_neg, 64'd63, 2'b00, 1'b0);
		add_entry(alu_sra, m_ri, fwd_reg, fwd_reg, min_neg, 64'd32, 2'b00, 1'b0);
		add_entry(alu_sllw, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd31, 2'b01, 1'b0);
		add_entry(alu_sllw, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd32, 2'b01, 1'b0);
		add_entry(alu_srlw, m_rr, fwd_reg, fwd_reg, all_ones, 64'd31, 2'b00, 1'b0);
		add_entry(alu_sraw, m_rr, fwd_reg, fwd_reg, 64'h8000_0000, 64'd4, 2'b00, 1'b0);
		add_entry(alu_lui, m_ri, fwd_reg, fwd_reg, 64'd0, 64'h1234_5000, 2'b01, 1'b0);
		// Each branch condition taken and not taken.
		add_entry(alu_beq, m_rr, fwd_reg, fwd_reg, 64'd5, 64'd5, 2'b00, 1'b1);
		add_entry(alu_beq, m_rr, fwd_reg, fwd_reg, 64'd5, 64'd6, 2'b00, 1'b0);
		add_entry(alu_bne, m_rr, fwd_reg, fwd_reg, 64'd5, 64'd6, 2'b00, 1'b1);
		add_entry(alu_bne, m_rr, fwd_reg, fwd_reg, 64'd5, 64'd5, 2'b00, 1'b0);
		add_entry(alu_blt, m_rr, fwd_reg, fwd_reg, min_neg, max_pos, 2'b00, 1'b1);
		add_entry(alu_blt, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b0);
		add_entry(alu_bge, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b1);
		add_entry(alu_bge, m_rr, fwd_reg, fwd_reg, min_neg, max_pos, 2'b00, 1'b0);
		add_entry(alu_bltu, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b1);
		add_entry(alu_bltu, m_rr, fwd_reg, fwd_reg, all_ones, 64'd1, 2'b00, 1'b0);
		add_entry(alu_bgeu, m_rr, fwd_reg, fwd_reg, all_ones, 64'd1, 2'b00, 1'b1);
		add_entry(alu_bgeu, m_rr, fwd_reg, fwd_reg, 64'd1, all_ones, 2'b00, 1'b0);
		// JALR with an odd sum, then JAL.
		add_entry(alu_add, m_jalr, fwd_reg, fwd_reg, 64'h1001, 64'h10, 2'b00, 1'b0);
		add_entry(alu_add, m_jal, fwd_reg, fwd_reg, 64'd0, 64'h800, 2'b01, 1'b0);
		// Dependent chain, register file values are random junk.
		add_entry(alu_add, m_rr, fwd_reg, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_add, m_rr, fwd_mem, fwd_reg, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_sub, m_rr, fwd_wb, fwd_mem, 64'd0, 64'd0, 2'b11, 1'b0);
		add_entry(alu_xor, m_rr, fwd_mem, fwd_wb, 64'd0, 64'd0, 2'b11, 1'b0);
	endfunction

	// History of expected results stands in for EX/MEM and MEM/WB.
	function automatic reg_t forwarded_value(fwd_sel_e sel, reg_t rf_val, int i);
		case (sel)
			fwd_mem: return exp_q[i - 1].alu_result;
			fwd_wb:  return exp_q[i - 2].alu_result;
			default: return rf_val;
		endcase
	endfunction

	function automatic void check_value(string name, int t, reg_t got, reg_t exp);
		assert (got === exp)
		else begin
			$display("error: %s in test %0d is %h, expected %h", name, t, got, exp);
			bad_q[t] = 1'b1;
		end
	endfunction

	function automatic void report_test(int t);
		entry_t e;
		string verdict;
		if (bad_q[t]) begin
			verdict = "FAILED";
			fail_count++;
		end else begin
			verdict = "ok";
			pass_count++;
		end
		if (t == 0) begin
			$display("reset and bubbles: %s", verdict);
		end else begin
			e = table_q[t - 1];
			$display("entry %0d %s: %s", t - 1, e.op.name(), verdict);
		end
	endfunction

	// ex_out holds entry ie and wb_out holds entry iw, or a bubble.
	function automatic void check_outputs(int ie, int iw);
		ex_result_t x;
		if (ie >= 0 && ie < exp_q.size()) begin
			x = exp_q[ie];
			check_value("ex_out.valid", ie + 1, reg_t'(ex_out.valid), reg_t'(x.valid));
			check_value("ex_out.alu_result", ie + 1, ex_out.alu_result, x.alu_result);
			check_value("ex_out.store_data", ie + 1, ex_out.store_data, x.store_data);
			check_value("ex_out.target_pc", ie + 1, ex_out.target_pc, x.target_pc);
			check_value("ex_out.taken", ie + 1, reg_t'(ex_out.taken), reg_t'(x.taken));
		end else begin
			check_value("ex_out.valid", 0, reg_t'(ex_out.valid), '0);
		end
		if (iw >= 0 && iw < exp_q.size()) begin
			x = exp_q[iw];
			check_value("wb_out.valid", iw + 1, reg_t'(wb_out.valid), reg_t'(x.valid));
			check_value("wb_out.rd_data", iw + 1, wb_out.rd_data, x.alu_result);
			report_test(iw + 1);
		end else begin
			check_value("wb_out.valid", 0, reg_t'(wb_out.valid), '0);
		end
	endfunction

	initial begin
		entry_t     e;
		issue_t     req;
		ex_result_t x;
		reg_t       pc;
		reg_t       imm;
		reg_t       rs1_eff;
		reg_t       rs2_eff;
		reg_t       op1;
		reg_t       op2;
		rst = 1'b1;
		issue = '0;
		issue.valid = 1'b1; // A valid add, so only reset keeps the registers empty.
		build_table();
		repeat (table_q.size() + 1) bad_q.push_back(1'b0);
		table_built = 1'b1;
		repeat (10) begin
			@(negedge clk);
			check_value("ex_out.valid", 0, reg_t'(ex_out.valid), '0);
			check_value("wb_out.valid", 0, reg_t'(wb_out.valid), '0);
		end
		@(posedge clk);
		rst <= 1'b0;
		issue <= '0;
		for (int i = 0; i < table_q.size() + 2; i++) begin
			@(posedge clk);
			if (i < table_q.size()) begin
				e = table_q[i];
				if (e.rnd[0])
					e.a = random_dword();
				if (e.rnd[1])
					e.b = random_dword();
				pc = pc_base + (reg_t'(i) << 2);
				imm = (e.mode == m_rr) ? branch_off : e.b;
				rs1_eff = forwarded_value(e.f1, e.a, i);
				rs2_eff = forwarded_value(e.f2, e.b, i);
				op1 = e.mode[1] ? pc : rs1_eff; // Jumps link from pc.
				op2 = e.mode[1] ? 64'd4 : ((e.mode == m_ri) ? e.b : rs2_eff);
				x.valid = 1'b1;
				x.alu_result = ref_alu(e.op, op1, op2);
				x.store_data = rs2_eff;
				x.target_pc = ref_target(pc, rs1_eff, imm, e.mode == m_jalr);
				x.taken = ref_taken(e.op, op1, op2);
				assert (x.taken == e.taken)
				else begin
					$display("entry %0d has a taken bit in the table that disagrees with the model",
						i);
					bad_q[i + 1] = 1'b1;
				end
				exp_q.push_back(x);
				req.valid = 1'b1;
				req.alu_op = e.op;
				req.pc = pc;
				req.imm = imm;
				req.rs1_data = e.a;
				req.rs2_data = e.b;
				req.rs1_fwd = e.f1;
				req.rs2_fwd = e.f2;
				req.op1_sel = e.mode[1] ? op1_pc : op1_rs1;
				req.op2_sel = e.mode[1] ? op2_const4 : ((e.mode == m_ri) ? op2_imm : op2_rs2);
				req.pc_from_rs1 = (e.mode == m_jalr);
				issue <= req;
			end else begin
				issue <= '0; // Bubbles drain the pipe.
			end
			@(negedge clk);
			check_outputs(i - 1, i - 2);
		end
		report_test(0);
		$display("%0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Table length plus margin for reset and draining.
	initial begin
		wait (table_built);
		#((table_q.size() + 20) * 100);
		$display("timeout: the run did not finish within %0d cycles", table_q.size() + 20);
		$display("test failed");
		$finish;
	end

endmodule
